/* design/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam logic [CSR_ADDR_W-1:0] CSR_TID = 14'h040;  // timer id

    localparam int PLV_W = 2;
    localparam logic [PLV_W-1:0] PLV_KERNEL = 2'd0;
    localparam logic [PLV_W-1:0] PLV_USER   = 2'd3;

endpackage

/* design/decode_pkg.sv */
package decode_pkg;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_i26_t;

    typedef union packed {
        inst_2ri12_t ri12;
        inst_i26_t   i26;
    } inst_word_t;

    // privileged and counter group, compared on inst[31:10]
    localparam logic [21:0] OP_ERTN     = 22'h1920E;
    localparam logic [21:0] OP_RDCNTID  = 22'h00018;  // shared with rdcntvl.w
    localparam logic [21:0] OP_RDCNTVHW = 22'h00019;
    localparam logic [21:0] OP_TLBSRCH  = 22'h1920A;
    localparam logic [21:0] OP_TLBRD    = 22'h1920B;
    localparam logic [21:0] OP_TLBWR    = 22'h1920C;
    localparam logic [21:0] OP_TLBFILL  = 22'h1920D;

    // 2r-i12 group, inst[31:22]
    localparam logic [9:0] OP_ADDIW = 10'h00A;
    localparam logic [9:0] OP_SLTI  = 10'h008;
    localparam logic [9:0] OP_SLTUI = 10'h009;
    localparam logic [9:0] OP_ANDI  = 10'h00D;
    localparam logic [9:0] OP_ORI   = 10'h00E;
    localparam logic [9:0] OP_XORI  = 10'h00F;
    localparam logic [9:0] OP_LDW   = 10'h0A2;
    localparam logic [9:0] OP_STW   = 10'h0A6;

    // i26 group, inst[31:26]
    localparam logic [5:0] OP_B  = 6'h14;
    localparam logic [5:0] OP_BL = 6'h15;

    localparam int ALU_OP_W = 8;
    localparam logic [ALU_OP_W-1:0] ALU_NOP     = 8'h00;
    localparam logic [ALU_OP_W-1:0] ALU_ADD     = 8'h01;
    localparam logic [ALU_OP_W-1:0] ALU_SLT     = 8'h02;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU    = 8'h03;
    localparam logic [ALU_OP_W-1:0] ALU_AND     = 8'h04;
    localparam logic [ALU_OP_W-1:0] ALU_OR      = 8'h05;
    localparam logic [ALU_OP_W-1:0] ALU_XOR     = 8'h06;
    localparam logic [ALU_OP_W-1:0] ALU_LDW     = 8'h07;
    localparam logic [ALU_OP_W-1:0] ALU_STW     = 8'h08;
    localparam logic [ALU_OP_W-1:0] ALU_B       = 8'h09;
    localparam logic [ALU_OP_W-1:0] ALU_BL      = 8'h0A;
    localparam logic [ALU_OP_W-1:0] ALU_ERTN    = 8'h0B;
    localparam logic [ALU_OP_W-1:0] ALU_RDCNTID = 8'h0C;
    localparam logic [ALU_OP_W-1:0] ALU_RDCNTVL = 8'h0D;
    localparam logic [ALU_OP_W-1:0] ALU_RDCNTVH = 8'h0E;
    localparam logic [ALU_OP_W-1:0] ALU_TLBSRCH = 8'h0F;
    localparam logic [ALU_OP_W-1:0] ALU_TLBRD   = 8'h10;
    localparam logic [ALU_OP_W-1:0] ALU_TLBWR   = 8'h11;
    localparam logic [ALU_OP_W-1:0] ALU_TLBFILL = 8'h12;

    localparam int ALU_SEL_W = 3;
    localparam logic [ALU_SEL_W-1:0] SEL_NOP   = 3'd0;
    localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'd1;
    localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'd2;
    localparam logic [ALU_SEL_W-1:0] SEL_MEM   = 3'd3;
    localparam logic [ALU_SEL_W-1:0] SEL_JUMP  = 3'd4;
    localparam logic [ALU_SEL_W-1:0] SEL_CSR   = 3'd5;

    localparam int ECODE_W = 7;
    localparam logic [ECODE_W-1:0] EXC_NONE = 7'h00;
    localparam logic [ECODE_W-1:0] EXC_INE  = 7'h0D;
    localparam logic [ECODE_W-1:0] EXC_IPE  = 7'h0E;

    localparam logic [4:0] REG_RA = 5'd1;  // link register for bl

endpackage

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*, csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [PLV_W-1:0]      plv,
    input  logic [31:0]           pc,
    input  logic [31:0]           inst,
    output logic                  valid_out,
    output logic [31:0]           pc_out,
    output logic [31:0]           inst_out,
    output logic                  reg_write_en,
    output logic [4:0]            reg_write_addr,
    output logic                  reg1_read_en,
    output logic [4:0]            reg1_read_addr,
    output logic                  reg2_read_en,
    output logic [4:0]            reg2_read_addr,
    output logic [ALU_OP_W-1:0]   aluop,
    output logic [ALU_SEL_W-1:0]  alusel,
    output logic [31:0]           imm,
    output logic                  csr_read_en,
    output logic                  csr_write_en,
    output logic [CSR_ADDR_W-1:0] csr_addr,
    output logic                  is_privilege,
    output logic                  is_cnt,
    output logic                  is_exception,
    output logic [ECODE_W-1:0]    exception_cause
);

    logic                  priv_hit;
    logic                  priv_reg_write_en;
    logic                  priv_reg1_read_en;
    logic                  priv_csr_read_en;
    logic                  priv_is_privilege;
    logic                  priv_is_cnt;
    logic [4:0]            priv_reg_write_addr;
    logic [4:0]            priv_reg1_read_addr;
    logic [ALU_OP_W-1:0]   priv_aluop;
    logic [ALU_SEL_W-1:0]  priv_alusel;
    logic [CSR_ADDR_W-1:0] priv_csr_addr;

    logic                  ari_hit;
    logic                  ari_reg_write_en;
    logic                  ari_reg1_read_en;
    logic                  ari_reg2_read_en;
    logic [4:0]            ari_reg1_read_addr;
    logic [4:0]            ari_reg2_read_addr;
    logic [4:0]            ari_reg_write_addr;
    logic [ALU_OP_W-1:0]   ari_aluop;
    logic [ALU_SEL_W-1:0]  ari_alusel;
    logic [31:0]           ari_imm;

    logic                  br_hit;
    logic                  br_reg_write_en;
    logic [4:0]            br_reg_write_addr;
    logic [ALU_OP_W-1:0]   br_aluop;
    logic [ALU_SEL_W-1:0]  br_alusel;
    logic [31:0]           br_imm;

    id_priv id_priv_i (
        .inst           (inst),
        .hit            (priv_hit),
        .reg_write_en   (priv_reg_write_en),
        .reg1_read_en   (priv_reg1_read_en),
        .csr_read_en    (priv_csr_read_en),
        .is_privilege   (priv_is_privilege),
        .is_cnt         (priv_is_cnt),
        .reg_write_addr (priv_reg_write_addr),
        .reg1_read_addr (priv_reg1_read_addr),
        .aluop          (priv_aluop),
        .alusel         (priv_alusel),
        .csr_addr       (priv_csr_addr)
    );

    id_2ri12 id_2ri12_i (
        .inst           (inst),
        .hit            (ari_hit),
        .reg_write_en   (ari_reg_write_en),
        .reg1_read_en   (ari_reg1_read_en),
        .reg2_read_en   (ari_reg2_read_en),
        .reg1_read_addr (ari_reg1_read_addr),
        .reg2_read_addr (ari_reg2_read_addr),
        .reg_write_addr (ari_reg_write_addr),
        .aluop          (ari_aluop),
        .alusel         (ari_alusel),
        .imm            (ari_imm)
    );

    id_i26 id_i26_i (
        .inst           (inst),
        .hit            (br_hit),
        .reg_write_en   (br_reg_write_en),
        .reg_write_addr (br_reg_write_addr),
        .aluop          (br_aluop),
        .alusel         (br_alusel),
        .imm            (br_imm)
    );

    // partial decode nets share the prefixed port names
    id_result_reg id_result_reg_i (.*);

endmodule

/* design/id_2ri12.sv */
`timescale 1ns/1ps

module id_2ri12
    import decode_pkg::*;
(
    input  inst_word_t           inst,
    output logic                 hit,
    output logic                 reg_write_en,
    output logic                 reg1_read_en,
    output logic                 reg2_read_en,
    output logic [4:0]           reg1_read_addr,
    output logic [4:0]           reg2_read_addr,
    output logic [4:0]           reg_write_addr,
    output logic [ALU_OP_W-1:0]  aluop,
    output logic [ALU_SEL_W-1:0] alusel,
    output logic [31:0]          imm
);

    logic        zero_ext;  // logic ops take an unsigned immediate
    logic [11:0] imm12;

    assign imm12 = inst.ri12.imm12;

    always_comb begin
        hit          = 1'b1;
        zero_ext     = 1'b0;
        reg_write_en = 1'b1;
        reg2_read_en = 1'b0;
        aluop        = ALU_NOP;
        alusel       = SEL_ARITH;
        case (inst.ri12.opcode)
            OP_ADDIW: aluop = ALU_ADD;
            OP_SLTI:  aluop = ALU_SLT;
            OP_SLTUI: aluop = ALU_SLTU;
            OP_ANDI: begin
                aluop    = ALU_AND;
                alusel   = SEL_LOGIC;
                zero_ext = 1'b1;
            end
            OP_ORI: begin
                aluop    = ALU_OR;
                alusel   = SEL_LOGIC;
                zero_ext = 1'b1;
            end
            OP_XORI: begin
                aluop    = ALU_XOR;
                alusel   = SEL_LOGIC;
                zero_ext = 1'b1;
            end
            OP_LDW: begin
                aluop  = ALU_LDW;
                alusel = SEL_MEM;
            end
            OP_STW: begin
                aluop        = ALU_STW;
                alusel       = SEL_MEM;
                reg_write_en = 1'b0;
                reg2_read_en = 1'b1;  // store data comes from rd
            end
            default: begin
                hit          = 1'b0;
                reg_write_en = 1'b0;
                alusel       = SEL_NOP;
            end
        endcase
    end

    assign reg1_read_en   = hit;
    assign reg1_read_addr = hit ? inst.ri12.rj : 5'd0;
    assign reg2_read_addr = reg2_read_en ? inst.ri12.rd : 5'd0;
    assign reg_write_addr = reg_write_en ? inst.ri12.rd : 5'd0;

    assign imm = !hit     ? 32'd0 :
                 zero_ext ? {20'd0, imm12} :
                            {{20{imm12[11]}}, imm12};

endmodule

/* design/id_i26.sv */
`timescale 1ns/1ps

module id_i26
    import decode_pkg::*;
(
    input  inst_word_t           inst,
    output logic                 hit,
    output logic                 reg_write_en,
    output logic [4:0]           reg_write_addr,
    output logic [ALU_OP_W-1:0]  aluop,
    output logic [ALU_SEL_W-1:0] alusel,
    output logic [31:0]          imm
);

    logic [25:0] offs;
    logic        is_bl;

    assign offs  = {inst.i26.offs_hi, inst.i26.offs_lo};  // high bits sit in [9:0]
    assign is_bl = (inst.i26.opcode == OP_BL);
    assign hit   = is_bl || (inst.i26.opcode == OP_B);

    assign reg_write_en   = is_bl;
    assign reg_write_addr = is_bl ? REG_RA : 5'd0;
    assign aluop          = !hit ? ALU_NOP : (is_bl ? ALU_BL : ALU_B);
    assign alusel         = hit ? SEL_JUMP : SEL_NOP;

    // word offset, sign-extended from bit 27
    assign imm = hit ? {{4{offs[25]}}, offs, 2'b00} : 32'd0;

endmodule

/* design/id_priv.sv */
`timescale 1ns/1ps

module id_priv
    import decode_pkg::*, csr_pkg::*;
(
    input  logic [31:0]           inst,
    output logic                  hit,
    output logic                  reg_write_en,
    output logic                  reg1_read_en,
    output logic                  csr_read_en,
    output logic                  is_privilege,
    output logic                  is_cnt,
    output logic [4:0]            reg_write_addr,
    output logic [4:0]            reg1_read_addr,
    output logic [ALU_OP_W-1:0]   aluop,
    output logic [ALU_SEL_W-1:0]  alusel,
    output logic [CSR_ADDR_W-1:0] csr_addr
);

    logic [21:0] opcode;
    logic [4:0]  rj;
    logic [4:0]  rd;

    assign opcode = inst[31:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];

    // nothing in this group reads a gpr
    assign reg1_read_en   = 1'b0;
    assign reg1_read_addr = 5'd0;

    always_comb begin
        hit            = 1'b1;
        reg_write_en   = 1'b0;
        reg_write_addr = 5'd0;
        csr_read_en    = 1'b0;
        csr_addr       = '0;
        is_privilege   = 1'b1;
        is_cnt         = 1'b0;
        aluop          = ALU_NOP;
        alusel         = SEL_CSR;
        case (opcode)
            OP_ERTN: begin
                aluop  = ALU_ERTN;
                alusel = SEL_NOP;
            end
            OP_RDCNTID: begin
                is_privilege = 1'b0;
                is_cnt       = 1'b1;
                reg_write_en = 1'b1;
                if (rj != 5'd0) begin  // rdcntid.w, dest in rj
                    aluop          = ALU_RDCNTID;
                    reg_write_addr = rj;
                    csr_read_en    = 1'b1;
                    csr_addr       = CSR_TID;
                end else begin  // rdcntvl.w
                    aluop          = ALU_RDCNTVL;
                    reg_write_addr = rd;
                end
            end
            OP_RDCNTVHW: begin
                is_privilege   = 1'b0;
                is_cnt         = 1'b1;
                reg_write_en   = 1'b1;
                reg_write_addr = rd;
                aluop          = ALU_RDCNTVH;
            end
            OP_TLBSRCH: aluop = ALU_TLBSRCH;
            OP_TLBRD:   aluop = ALU_TLBRD;
            OP_TLBWR:   aluop = ALU_TLBWR;
            OP_TLBFILL: aluop = ALU_TLBFILL;
            default: begin
                hit          = 1'b0;
                is_privilege = 1'b0;
                alusel       = SEL_NOP;
            end
        endcase
    end

endmodule

/* design/id_result_reg.sv */
`timescale 1ns/1ps

module id_result_reg
    import decode_pkg::*, csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [PLV_W-1:0]      plv,
    input  logic [31:0]           pc,
    input  logic [31:0]           inst,
    input  logic                  priv_hit,
    input  logic                  priv_reg_write_en,
    input  logic                  priv_reg1_read_en,
    input  logic                  priv_csr_read_en,
    input  logic                  priv_is_privilege,
    input  logic                  priv_is_cnt,
    input  logic [4:0]            priv_reg_write_addr,
    input  logic [4:0]            priv_reg1_read_addr,
    input  logic [ALU_OP_W-1:0]   priv_aluop,
    input  logic [ALU_SEL_W-1:0]  priv_alusel,
    input  logic [CSR_ADDR_W-1:0] priv_csr_addr,
    input  logic                  ari_hit,
    input  logic                  ari_reg_write_en,
    input  logic                  ari_reg1_read_en,
    input  logic                  ari_reg2_read_en,
    input  logic [4:0]            ari_reg1_read_addr,
    input  logic [4:0]            ari_reg2_read_addr,
    input  logic [4:0]            ari_reg_write_addr,
    input  logic [ALU_OP_W-1:0]   ari_aluop,
    input  logic [ALU_SEL_W-1:0]  ari_alusel,
    input  logic [31:0]           ari_imm,
    input  logic                  br_hit,
    input  logic                  br_reg_write_en,
    input  logic [4:0]            br_reg_write_addr,
    input  logic [ALU_OP_W-1:0]   br_aluop,
    input  logic [ALU_SEL_W-1:0]  br_alusel,
    input  logic [31:0]           br_imm,
    output logic                  valid_out,
    output logic [31:0]           pc_out,
    output logic [31:0]           inst_out,
    output logic                  reg_write_en,
    output logic [4:0]            reg_write_addr,
    output logic                  reg1_read_en,
    output logic [4:0]            reg1_read_addr,
    output logic                  reg2_read_en,
    output logic [4:0]            reg2_read_addr,
    output logic [ALU_OP_W-1:0]   aluop,
    output logic [ALU_SEL_W-1:0]  alusel,
    output logic [31:0]           imm,
    output logic                  csr_read_en,
    output logic                  csr_write_en,
    output logic [CSR_ADDR_W-1:0] csr_addr,
    output logic                  is_privilege,
    output logic                  is_cnt,
    output logic                  is_exception,
    output logic [ECODE_W-1:0]    exception_cause
);

    logic any_hit;
    logic ipe;
    logic kill;
    logic load;

    assign any_hit = priv_hit | ari_hit | br_hit;
    assign ipe     = priv_is_privilege & (plv == PLV_USER);
    assign kill    = ~any_hit | ipe;  // exception suppresses all enables
    assign load    = valid_in & ~kill;

    assign csr_write_en = 1'b0;  // no csr writer decoded here yet

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out    <= 1'b0;
            reg_write_en <= 1'b0;
            reg1_read_en <= 1'b0;
            reg2_read_en <= 1'b0;
            csr_read_en  <= 1'b0;
            is_privilege <= 1'b0;
            is_cnt       <= 1'b0;
            is_exception <= 1'b0;
        end else if (flush) begin
            valid_out    <= 1'b0;
            reg_write_en <= 1'b0;
            reg1_read_en <= 1'b0;
            reg2_read_en <= 1'b0;
            csr_read_en  <= 1'b0;
            is_privilege <= 1'b0;
            is_cnt       <= 1'b0;
            is_exception <= 1'b0;
        end else if (!stall) begin
            valid_out    <= valid_in;
            reg_write_en <= load & (priv_reg_write_en | ari_reg_write_en | br_reg_write_en);
            reg1_read_en <= load & (priv_reg1_read_en | ari_reg1_read_en);
            reg2_read_en <= load & ari_reg2_read_en;
            csr_read_en  <= load & priv_csr_read_en;
            is_privilege <= valid_in & priv_is_privilege;
            is_cnt       <= valid_in & priv_is_cnt;
            is_exception <= valid_in & kill;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_out          <= pc;
            inst_out        <= inst;
            reg_write_addr  <= priv_reg_write_addr | ari_reg_write_addr | br_reg_write_addr;
            reg1_read_addr  <= priv_reg1_read_addr | ari_reg1_read_addr;
            reg2_read_addr  <= ari_reg2_read_addr;
            aluop           <= priv_aluop | ari_aluop | br_aluop;
            alusel          <= priv_alusel | ari_alusel | br_alusel;
            imm             <= ari_imm | br_imm;
            csr_addr        <= priv_csr_addr;
            exception_cause <= !any_hit ? EXC_INE : (ipe ? EXC_IPE : EXC_NONE);
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_decode_stage -f src.f -o sim_decode

out=$(./obj_dir/sim_decode)
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD = 40  // ns
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
    import decode_pkg::*, csr_pkg::*;
();

    localparam int MAX_CYCLES = 600;  // sequence needs about 140 cycles
    localparam logic [21:0] PRIV_OPS [7] = '{OP_ERTN, OP_RDCNTID, OP_RDCNTVHW,
        OP_TLBSRCH, OP_TLBRD, OP_TLBWR, OP_TLBFILL};
    localparam logic [9:0] ARI_OPS [8] = '{OP_ADDIW, OP_SLTI, OP_SLTUI, OP_ANDI,
        OP_ORI, OP_XORI, OP_LDW, OP_STW};

    logic                  clk;
    logic                  rst_n;
    logic                  valid_in;
    logic                  stall;
    logic                  flush;
    logic [PLV_W-1:0]      plv;
    logic [31:0]           pc;
    logic [31:0]           inst;
    logic                  valid_out;
    logic [31:0]           pc_out;
    logic [31:0]           inst_out;
    logic                  reg_write_en;
    logic [4:0]            reg_write_addr;
    logic                  reg1_read_en;
    logic [4:0]            reg1_read_addr;
    logic                  reg2_read_en;
    logic [4:0]            reg2_read_addr;
    logic [ALU_OP_W-1:0]   aluop;
    logic [ALU_SEL_W-1:0]  alusel;
    logic [31:0]           imm;
    logic                  csr_read_en;
    logic                  csr_write_en;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  is_privilege;
    logic                  is_cnt;
    logic                  is_exception;
    logic [ECODE_W-1:0]    exception_cause;

    // expected registered outputs
    logic                  e_valid, e_exc, e_wen, e_r1en, e_r2en, e_csren, e_priv, e_cnt;
    logic [4:0]            e_waddr, e_r1addr, e_r2addr;
    logic [ALU_OP_W-1:0]   e_aluop;
    logic [ALU_SEL_W-1:0]  e_alusel;
    logic [31:0]           e_imm, e_pc, e_inst;
    logic [CSR_ADDR_W-1:0] e_csraddr;
    logic [ECODE_W-1:0]    e_cause;
    int                    errors;
    int                    checks;

    clk_gen clk_gen_i (.clk(clk));

    decode_stage decode_stage_i (.*);

    task automatic chk(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic clear_expect();
        e_valid = 1'b0;
        e_wen   = 1'b0;
        e_r1en  = 1'b0;
        e_r2en  = 1'b0;
        e_csren = 1'b0;
    endtask

    // reference decode of one word
    task automatic predict(input logic [31:0] w, input logic [PLV_W-1:0] p);
        logic [21:0] op22;
        logic [9:0]  op10;
        logic [4:0]  rj;
        logic [4:0]  rd;
        logic [11:0] i12;
        logic [25:0] offs;
        logic        hit;
        op22 = w[31:10];
        op10 = w[31:22];
        rj   = w[9:5];
        rd   = w[4:0];
        i12  = w[21:10];
        offs = {w[9:0], w[25:10]};  // offs[25:16] lives in the low bits
        hit  = 1'b1;
        {e_wen, e_r1en, e_r2en, e_csren, e_priv, e_cnt} = '0;
        {e_waddr, e_r1addr, e_r2addr} = '0;
        e_aluop   = ALU_NOP;
        e_alusel  = SEL_NOP;
        e_imm     = '0;
        e_csraddr = '0;
        e_valid   = 1'b1;
        e_pc      = pc;
        e_inst    = w;
        if (op22 inside {OP_RDCNTID, OP_RDCNTVHW}) begin
            e_cnt    = 1'b1;
            e_wen    = 1'b1;
            e_waddr  = rd;
            e_alusel = SEL_CSR;
            e_aluop  = (op22 == OP_RDCNTVHW) ? ALU_RDCNTVH : ALU_RDCNTVL;
            if (op22 == OP_RDCNTID && rj != 5'd0) begin  // rdcntid.w form
                e_aluop   = ALU_RDCNTID;
                e_waddr   = rj;
                e_csren   = 1'b1;
                e_csraddr = CSR_TID;
            end
        end else if (op22 inside {OP_ERTN, OP_TLBSRCH, OP_TLBRD, OP_TLBWR, OP_TLBFILL}) begin
            e_priv   = 1'b1;
            e_alusel = (op22 == OP_ERTN) ? SEL_NOP : SEL_CSR;
            case (op22)
                OP_ERTN:    e_aluop = ALU_ERTN;
                OP_TLBSRCH: e_aluop = ALU_TLBSRCH;
                OP_TLBRD:   e_aluop = ALU_TLBRD;
                OP_TLBWR:   e_aluop = ALU_TLBWR;
                default:    e_aluop = ALU_TLBFILL;
            endcase
        end else if (op10 inside {OP_ADDIW, OP_SLTI, OP_SLTUI, OP_ANDI, OP_ORI, OP_XORI,
                                  OP_LDW, OP_STW}) begin
            e_r1en   = 1'b1;
            e_r1addr = rj;
            e_wen    = 1'b1;
            e_waddr  = rd;
            e_alusel = SEL_ARITH;
            e_imm    = {{20{i12[11]}}, i12};
            case (op10)
                OP_ADDIW: e_aluop = ALU_ADD;
                OP_SLTI:  e_aluop = ALU_SLT;
                OP_SLTUI: e_aluop = ALU_SLTU;
                OP_ANDI:  e_aluop = ALU_AND;
                OP_ORI:   e_aluop = ALU_OR;
                OP_XORI:  e_aluop = ALU_XOR;
                OP_LDW:   e_aluop = ALU_LDW;
                default:  e_aluop = ALU_STW;
            endcase
            if (op10 inside {OP_ANDI, OP_ORI, OP_XORI}) begin  // zero-extended
                e_alusel = SEL_LOGIC;
                e_imm    = {20'd0, i12};
            end
            if (op10 inside {OP_LDW, OP_STW})
                e_alusel = SEL_MEM;
            if (op10 == OP_STW) begin  // st.w reads rd and writes nothing
                e_wen    = 1'b0;
                e_waddr  = 5'd0;
                e_r2en   = 1'b1;
                e_r2addr = rd;
            end
        end else if (w[31:26] inside {OP_B, OP_BL}) begin
            e_alusel = SEL_JUMP;
            e_imm    = {{6{offs[25]}}, offs} << 2;
            e_aluop  = (w[31:26] == OP_BL) ? ALU_BL : ALU_B;
            e_wen    = (w[31:26] == OP_BL);
            e_waddr  = e_wen ? 5'd1 : 5'd0;
        end else begin
            hit = 1'b0;
        end
        e_exc   = !hit || (e_priv && p == PLV_USER);
        e_cause = !hit ? EXC_INE : (e_exc ? EXC_IPE : EXC_NONE);
        if (e_exc) begin
            e_wen   = 1'b0;
            e_r1en  = 1'b0;
            e_r2en  = 1'b0;
            e_csren = 1'b0;
        end
    endtask

    task automatic compare();
        chk("valid_out", 32'(valid_out), 32'(e_valid));
        chk("reg_write_en", 32'(reg_write_en), 32'(e_wen));
        chk("reg1_read_en", 32'(reg1_read_en), 32'(e_r1en));
        chk("reg2_read_en", 32'(reg2_read_en), 32'(e_r2en));
        chk("csr_read_en", 32'(csr_read_en), 32'(e_csren));
        chk("csr_write_en", 32'(csr_write_en), 32'd0);
        if (e_valid) begin
            chk("is_exception", 32'(is_exception), 32'(e_exc));
            chk("exception_cause", 32'(exception_cause), 32'(e_cause));
        end else begin  // flags drop together with valid_out
            chk("is_privilege", 32'(is_privilege), 32'd0);
            chk("is_cnt", 32'(is_cnt), 32'd0);
            chk("is_exception", 32'(is_exception), 32'd0);
        end
        if (e_valid && !e_exc) begin
            chk("pc_out", pc_out, e_pc);
            chk("inst_out", inst_out, e_inst);
            chk("reg_write_addr", 32'(reg_write_addr), 32'(e_waddr));
            chk("reg1_read_addr", 32'(reg1_read_addr), 32'(e_r1addr));
            chk("reg2_read_addr", 32'(reg2_read_addr), 32'(e_r2addr));
            chk("aluop", 32'(aluop), 32'(e_aluop));
            chk("alusel", 32'(alusel), 32'(e_alusel));
            chk("imm", imm, e_imm);
            chk("csr_addr", 32'(csr_addr), 32'(e_csraddr));
            chk("is_privilege", 32'(is_privilege), 32'(e_priv));
            chk("is_cnt", 32'(is_cnt), 32'(e_cnt));
        end
    endtask

    // starts and ends on a falling edge
    task automatic send(input logic [31:0] w, input logic [PLV_W-1:0] p);
        valid_in = 1'b1;
        stall    = 1'b0;
        flush    = 1'b0;
        plv      = p;
        inst     = w;
        pc       = $urandom & ~32'd3;
        predict(w, p);
        @(posedge clk);
        @(negedge clk);
        compare();
    endtask

    initial begin
        logic [31:0] w;
        inst_word_t  iw;
        void'($urandom(91));
        errors   = 0;
        checks   = 0;
        rst_n    = 1'b0;
        valid_in = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        plv      = PLV_KERNEL;
        pc       = '0;
        inst     = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        clear_expect();
        compare();
        rst_n = 1'b1;

        for (int k = 0; k < 7; k++) begin
            for (int n = 0; n < 3; n++) begin
                w = {PRIV_OPS[k], 10'($urandom)};
                if (n == 0)
                    w[9:5] = 5'd0;  // rdcntvl.w for the shared opcode
                if (n == 1)
                    w[5] = 1'b1;
                send(w, PLV_KERNEL);
                send(w, PLV_USER);
            end
        end

        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 4; n++) begin
                iw = $urandom;
                iw.ri12.opcode = ARI_OPS[k];
                if (n == 0)
                    iw.ri12.imm12[11] = 1'b1;  // negative immediate
                send(iw, PLV_USER);
            end
        end

        for (int n = 0; n < 8; n++) begin
            iw = $urandom;
            iw.i26.opcode = n[0] ? OP_BL : OP_B;
            if (n < 2)
                iw.i26.offs_hi[9] = 1'b1;  // backward branch
            send(iw, PLV_USER);
        end

        repeat (40) send($urandom, PLV_W'($urandom));

        // stall holds the outputs and flush overrides stall
        send({OP_RDCNTID, 5'd7, 5'd3}, PLV_KERNEL);
        stall = 1'b1;
        inst  = $urandom;
        pc    = $urandom;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            compare();
        end
        flush = 1'b1;
        @(posedge clk);
        @(negedge clk);
        clear_expect();
        compare();

        // decodable word left on inst while valid_in is low
        send({OP_RDCNTID, 5'd12, 5'd2}, PLV_KERNEL);
        valid_in = 1'b0;
        @(posedge clk);
        @(negedge clk);
        clear_expect();
        compare();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        #(MAX_CYCLES * 40);
        $display("timeout: decode sequence still running after %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* src.f */
design/decode_pkg.sv
design/csr_pkg.sv
design/id_priv.sv
design/id_2ri12.sv
design/id_i26.sv
design/id_result_reg.sv
design/decode_stage.sv
sim/clk_gen.sv
sim/tb_decode_stage.sv
